// File: lcdPkg.sv
package lcdPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Host register map.
    ////////////////////////////////////////////////////////////////////////////
    localparam logic [2:0] REG_CTRL   = 3'd0; // Init start, backlight enable, overrun clear.
    localparam logic [2:0] REG_TIMING = 3'd1; // Strobe low and high widths.
    localparam logic [2:0] REG_CMD    = 3'd2; // Single command write.
    localparam logic [2:0] REG_DATA   = 3'd3; // Single data write.
    localparam logic [2:0] REG_STATUS = 3'd4; // Busy, initDone, backlight, overrun.

    // Strobe phase widths out of reset.
    localparam logic [3:0] DEFAULT_WR_LOW  = 4'd2;
    localparam logic [3:0] DEFAULT_WR_HIGH = 4'd2;

    // Panel reset pulse and recovery, in clocks.
    localparam logic [15:0] RESET_LOW_CYCLES     = 16'd64;
    localparam logic [15:0] RESET_RECOVER_CYCLES = 16'd32;

    ////////////////////////////////////////////////////////////////////////////
    // Init table.
    ////////////////////////////////////////////////////////////////////////////
    localparam int INIT_LEN    = 12;
    localparam int INIT_IDX_W  = $clog2(INIT_LEN);

    // Entry kinds, top two bits of an entry.
    localparam logic [1:0] KIND_CMD  = 2'd0;
    localparam logic [1:0] KIND_DATA = 2'd1;
    localparam logic [1:0] KIND_WAIT = 2'd2;
    localparam logic [1:0] KIND_END  = 2'd3;

    // One entry, read as a bus write or as a delay.
    typedef union packed {
        struct packed {
            logic [1:0]  kind;
            logic [15:0] word;   // Bus word for command or data.
        } wr;
        struct packed {
            logic [1:0]  kind;
            logic [15:0] cycles; // Delay length in clocks.
        } dly;
    } initEntry_u;

    localparam initEntry_u INIT_TABLE [INIT_LEN] = '{
        {KIND_CMD,  16'h0011}, // Sleep out.
        {KIND_WAIT, 16'h0078}, // Let the panel wake up.
        {KIND_CMD,  16'h003A}, // Pixel format.
        {KIND_DATA, 16'h0055}, // 16 bpp.
        {KIND_CMD,  16'h0036}, // Memory access control.
        {KIND_DATA, 16'h0000},
        {KIND_CMD,  16'h002A}, // Column address set.
        {KIND_DATA, 16'h0000},
        {KIND_DATA, 16'h01DF}, // Last column, 479.
        {KIND_CMD,  16'h0029}, // Display on.
        {KIND_WAIT, 16'h0014},
        {KIND_END,  16'h0000}  // Table stops here.
    };

    ////////////////////////////////////////////////////////////////////////////
    // FSM encodings.
    ////////////////////////////////////////////////////////////////////////////
    localparam logic [1:0] BT_IDLE = 2'd0;
    localparam logic [1:0] BT_LOW  = 2'd1;
    localparam logic [1:0] BT_HIGH = 2'd2;

    localparam logic [2:0] SQ_IDLE     = 3'd0;
    localparam logic [2:0] SQ_RST_LOW  = 3'd1;
    localparam logic [2:0] SQ_RECOVER  = 3'd2;
    localparam logic [2:0] SQ_FETCH    = 3'd3;
    localparam logic [2:0] SQ_ISSUE    = 3'd4;
    localparam logic [2:0] SQ_WAIT_DN  = 3'd5;
    localparam logic [2:0] SQ_DELAY    = 3'd6;
    localparam logic [2:0] SQ_FINISHED = 3'd7;

endpackage

// File: lcdBusTiming.sv
`timescale 1ns/10ps

module lcdBusTiming
    import lcdPkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,    // One-cycle launch, only while idle.
    input  logic        isData,   // 0 command, 1 data.
    input  logic [15:0] word,
    input  logic [3:0]  wrLow,    // Strobe low width, never 0.
    input  logic [3:0]  wrHigh,   // Strobe high width, never 0.
    output logic        lcdCs,
    output logic        lcdRs,
    output logic        lcdWr,
    output logic [15:0] lcdData,
    output logic        busy,
    output logic        done
);

    logic [1:0] state;
    logic [3:0] phaseCnt; // Counts 1..width inside a phase.
    logic [3:0] lowW;     // Widths frozen for this transfer.
    logic [3:0] highW;

    // Busy also covers the done cycle.
    assign busy = (state != BT_IDLE) | done;

    ////////////////////////////////////////////////////////////////////////////
    // Strobe FSM.
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= BT_IDLE;
            phaseCnt <= 4'd0;
            lcdCs    <= 1'b1; // Pins idle high.
            lcdRs    <= 1'b1;
            lcdWr    <= 1'b1;
            lcdData  <= 16'd0;
            done     <= 1'b0;
        end
        else
        begin
            done <= 1'b0; // Pulse by default.
            case (state)
                BT_IDLE:
                begin
                    if (start)
                    begin
                        // Select, address and data all settle with the falling strobe.
                        lcdCs    <= 1'b0;
                        lcdRs    <= isData;
                        lcdData  <= word;
                        lcdWr    <= 1'b0;
                        phaseCnt <= 4'd1;
                        state    <= BT_LOW;
                    end
                end
                BT_LOW:
                begin
                    if (phaseCnt == lowW)
                    begin
                        lcdWr    <= 1'b1; // Panel latches on this edge.
                        phaseCnt <= 4'd1;
                        state    <= BT_HIGH;
                    end
                    else
                    begin
                        phaseCnt <= phaseCnt + 4'd1;
                    end
                end
                BT_HIGH:
                begin
                    if (phaseCnt == highW)
                    begin
                        lcdCs <= 1'b1; // Deselect with the done pulse.
                        done  <= 1'b1;
                        state <= BT_IDLE;
                    end
                    else
                    begin
                        phaseCnt <= phaseCnt + 4'd1;
                    end
                end
                default: state <= BT_IDLE;
            endcase
        end
    end

    // Phase widths latched at launch.
    always_ff @(posedge clk)
    begin
        if (start && (state == BT_IDLE))
        begin
            lowW  <= wrLow;
            highW <= wrHigh;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks.
    ////////////////////////////////////////////////////////////////////////////
    // Strobe low only inside a selected cycle.
    wrInsideCs: assert property (@(posedge clk) disable iff (!rst_n) !lcdWr |-> !lcdCs);

    // Requesters must wait out a transfer.
    noStartBusy: assert property (@(posedge clk) disable iff (!rst_n) start |-> !busy);

endmodule

// File: lcdInitSequencer.sv
`timescale 1ns/10ps

module lcdInitSequencer
    import lcdPkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        initStart,  // Restarts power-up from any state.
    input  logic        engineBusy,
    input  logic        engineDone,
    output logic        lcdRst,     // Panel reset, active low.
    output logic        seqActive,
    output logic        seqStart,
    output logic        seqIsData,
    output logic [15:0] seqWord,
    output logic        initDone
);

    logic [2:0]            state;
    logic [15:0]           cnt;   // Reset, recovery and delay counter.
    logic [INIT_IDX_W-1:0] idx;   // Current table entry.
    initEntry_u            entry;

    assign entry = INIT_TABLE[idx];

    // Write payload comes straight from the table, idx holds through the transfer.
    assign seqIsData = (entry.wr.kind == KIND_DATA);
    assign seqWord   = entry.wr.word;

    // Owns the engine between start and the end entry.
    assign seqActive = (state != SQ_IDLE) && (state != SQ_FINISHED);

    ////////////////////////////////////////////////////////////////////////////
    // Power-up FSM.
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= SQ_IDLE;
            cnt      <= 16'd0;
            idx      <= '0;
            lcdRst   <= 1'b1;
            seqStart <= 1'b0;
            initDone <= 1'b0;
        end
        else if (initStart)
        begin
            lcdRst   <= 1'b0; // Reset pulse begins next cycle.
            cnt      <= 16'd0;
            idx      <= '0;
            seqStart <= 1'b0;
            initDone <= 1'b0;
            state    <= SQ_RST_LOW;
        end
        else
        begin
            seqStart <= 1'b0;
            case (state)
                SQ_RST_LOW:
                begin
                    if (cnt == RESET_LOW_CYCLES - 16'd1)
                    begin
                        lcdRst <= 1'b1;
                        cnt    <= 16'd0;
                        state  <= SQ_RECOVER;
                    end
                    else
                    begin
                        cnt <= cnt + 16'd1;
                    end
                end
                SQ_RECOVER:
                begin
                    if (cnt == RESET_RECOVER_CYCLES - 16'd1)
                        state <= SQ_FETCH;
                    else
                        cnt <= cnt + 16'd1;
                end
                SQ_FETCH:
                begin
                    case (entry.wr.kind)
                        KIND_CMD, KIND_DATA: state <= SQ_ISSUE;
                        KIND_WAIT:
                        begin
                            cnt   <= 16'd0;
                            state <= SQ_DELAY;
                        end
                        default:
                        begin
                            initDone <= 1'b1; // End entry, stays until next start.
                            state    <= SQ_FINISHED;
                        end
                    endcase
                end
                SQ_ISSUE:
                begin
                    // Host traffic may still be draining.
                    if (!engineBusy)
                    begin
                        seqStart <= 1'b1;
                        state    <= SQ_WAIT_DN;
                    end
                end
                SQ_WAIT_DN:
                begin
                    if (engineDone)
                    begin
                        idx   <= idx + 1'b1;
                        state <= SQ_FETCH;
                    end
                end
                SQ_DELAY:
                begin
                    if (cnt + 16'd1 >= entry.dly.cycles)
                    begin
                        idx   <= idx + 1'b1;
                        state <= SQ_FETCH;
                    end
                    else
                    begin
                        cnt <= cnt + 16'd1;
                    end
                end
                default: ; // Idle and finished hold.
            endcase
        end
    end

    // Host launches are locked out while active, so the engine is still free.
    seqStartIdle: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(seqStart) |-> !engineBusy);

endmodule

// File: lcdConfigRegs.sv
`timescale 1ns/10ps

module lcdConfigRegs
    import lcdPkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        regWrite,
    input  logic [2:0]  regAddr,
    input  logic [15:0] regWdata,
    input  logic        engineBusy,
    input  logic        seqActive,
    input  logic        initDone,
    output logic [15:0] regRdata,
    output logic [3:0]  wrLow,
    output logic [3:0]  wrHigh,
    output logic        initStart,
    output logic        hostStart,
    output logic        hostIsData,
    output logic [15:0] hostWord,
    output logic        backlight
);

    logic blEnable;  // Backlight enable bit.
    logic overrun;   // Sticky, dropped launch.
    logic launchReq; // CMD or DATA write.
    logic blocked;   // Engine or sequencer owns the bus.

    ////////////////////////////////////////////////////////////////////////////
    // Write decode.
    ////////////////////////////////////////////////////////////////////////////
    assign launchReq = regWrite && ((regAddr == REG_CMD) || (regAddr == REG_DATA));
    assign blocked   = engineBusy | seqActive;

    assign initStart  = regWrite && (regAddr == REG_CTRL) && regWdata[0];
    assign hostStart  = launchReq && !blocked; // Goes straight to the engine.
    assign hostIsData = (regAddr == REG_DATA);
    assign hostWord   = regWdata;

    assign backlight = initDone & blEnable; // Dark until power-up ends.

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wrLow    <= DEFAULT_WR_LOW;
            wrHigh   <= DEFAULT_WR_HIGH;
            blEnable <= 1'b0;
            overrun  <= 1'b0;
        end
        else
        begin
            if (regWrite && (regAddr == REG_CTRL))
            begin
                blEnable <= regWdata[1];
                if (regWdata[2])
                    overrun <= 1'b0; // Write one to clear.
            end
            if (regWrite && (regAddr == REG_TIMING))
            begin
                // Zero width would stall the strobe, read it as one.
                wrLow  <= (regWdata[3:0] == 4'd0) ? 4'd1 : regWdata[3:0];
                wrHigh <= (regWdata[7:4] == 4'd0) ? 4'd1 : regWdata[7:4];
            end
            if (launchReq && blocked)
                overrun <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read back.
    ////////////////////////////////////////////////////////////////////////////
    always_comb
    begin
        case (regAddr)
            REG_CTRL:   regRdata = {14'd0, blEnable, 1'b0};
            REG_TIMING: regRdata = {8'd0, wrHigh, wrLow};
            REG_STATUS: regRdata = {12'd0, overrun, backlight, initDone, blocked};
            default:    regRdata = 16'd0; // Launch registers read as zero.
        endcase
    end

endmodule

// File: lcdController.sv
`timescale 1ns/10ps

module lcdController (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        regWrite,
    input  logic [2:0]  regAddr,
    input  logic [15:0] regWdata,
    output logic [15:0] regRdata,
    output logic        lcdRst,
    output logic        lcdCs,
    output logic        lcdRs,
    output logic        lcdWr,
    output logic        lcdRd,
    output logic [15:0] lcdData,
    output logic        blCtrl
);

    logic [3:0]  wrLow;
    logic [3:0]  wrHigh;
    logic        initStart;
    logic        hostStart;
    logic        hostIsData;
    logic [15:0] hostWord;
    logic        seqActive;
    logic        seqStart;
    logic        seqIsData;
    logic [15:0] seqWord;
    logic        initDone;
    logic        engStart;
    logic        engIsData;
    logic [15:0] engWord;
    logic        engBusy;
    logic        engDone;

    assign lcdRd = 1'b1; // Write-only bus.

    // Sequencer wins the engine while it runs.
    assign engStart  = seqActive ? seqStart  : hostStart;
    assign engIsData = seqActive ? seqIsData : hostIsData;
    assign engWord   = seqActive ? seqWord   : hostWord;

    lcdConfigRegs uRegs (
        .clk(clk), .rst_n(rst_n),
        .regWrite(regWrite), .regAddr(regAddr), .regWdata(regWdata),
        .engineBusy(engBusy), .seqActive(seqActive), .initDone(initDone),
        .regRdata(regRdata), .wrLow(wrLow), .wrHigh(wrHigh),
        .initStart(initStart), .hostStart(hostStart), .hostIsData(hostIsData),
        .hostWord(hostWord), .backlight(blCtrl)
    );

    lcdInitSequencer uSeq (
        .clk(clk), .rst_n(rst_n),
        .initStart(initStart), .engineBusy(engBusy), .engineDone(engDone),
        .lcdRst(lcdRst), .seqActive(seqActive), .seqStart(seqStart),
        .seqIsData(seqIsData), .seqWord(seqWord), .initDone(initDone)
    );

    lcdBusTiming uBus (
        .clk(clk), .rst_n(rst_n),
        .start(engStart), .isData(engIsData), .word(engWord),
        .wrLow(wrLow), .wrHigh(wrHigh),
        .lcdCs(lcdCs), .lcdRs(lcdRs), .lcdWr(lcdWr), .lcdData(lcdData),
        .busy(engBusy), .done(engDone)
    );

endmodule

// File: tbLcd.sv
`timescale 1ns/10ps

module tbLcd
    import lcdPkg::*;
();

    localparam int N_LAUNCH      = 300;
    localparam int MAX_XFER      = 1 + 15 + 15; // Start plus the widest strobe phases.
    localparam int HOST_OVERHEAD = 20;          // Register writes, polls and overrun probes.

    logic        clk;
    logic        rst_n;
    logic        regWrite;
    logic [2:0]  regAddr;
    logic [15:0] regWdata;
    logic [15:0] regRdata;
    logic        lcdRst;
    logic        lcdCs;
    logic        lcdRs;
    logic        lcdWr;
    logic        lcdRd;
    logic [15:0] lcdData;
    logic        blCtrl;

    integer      seed = 32'h1c02afad;
    int          cycleCnt = 0;
    int          cycleLimit = 0;
    logic [3:0]  curLow;           // Model copy of the timing register.
    logic [3:0]  curHigh;
    logic [24:0] expQ[$];          // {high, low, rs, data} per expected write.
    logic [24:0] expNow;
    int          csWidthExp = 0;   // Chip select low width of the last write.
    int          rstLowCnt = 0;
    int          wrLowCnt = 0;
    int          csLowCnt = 0;
    int          rstPulses = 0;
    logic        prevRst = 1'b1;
    logic        prevWr = 1'b1;
    logic        prevCs = 1'b1;

    lcdController dut (
        .clk(clk), .rst_n(rst_n),
        .regWrite(regWrite), .regAddr(regAddr), .regWdata(regWdata),
        .regRdata(regRdata), .lcdRst(lcdRst), .lcdCs(lcdCs), .lcdRs(lcdRs),
        .lcdWr(lcdWr), .lcdRd(lcdRd), .lcdData(lcdData), .blCtrl(blCtrl)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk; // 40 ns period.
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers.
    ////////////////////////////////////////////////////////////////////////////
    task automatic endFailed();
        $display("Testbench failed");
        $fatal(1, "Stopped at the first error.");
    endtask

    task automatic stopRun(input string why);
        $display("Error at time %0t: %s", $time, why);
        endFailed();
    endtask

    task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp)
        begin
            $display("mismatch at time %0t: %s, got 0x%0h, expected 0x%0h",
                     $time, what, got, exp);
            endFailed();
        end
    endtask

    // A zero phase width counts as one.
    function automatic logic [3:0] effWidth(input logic [3:0] w);
        return (w == 4'd0) ? 4'd1 : w;
    endfunction

    // Reset, recovery, all waits and all writes at the widest strobe.
    function automatic int powerUpCycles();
        int         total;
        initEntry_u e;
        total = RESET_LOW_CYCLES + RESET_RECOVER_CYCLES + 8;
        for (int k = 0; k < INIT_LEN; k++)
        begin
            e = INIT_TABLE[k];
            if (e.dly.kind == KIND_WAIT)
                total += e.dly.cycles + 2;
            else if (e.wr.kind != KIND_END)
                total += MAX_XFER + 4; // Fetch, issue and done handshake.
        end
        return total;
    endfunction

    task automatic pushExpected(input logic rs, input logic [15:0] data,
                                input logic [3:0] low, input logic [3:0] high);
        expQ.push_back({high, low, rs, data});
    endtask

    // Every bus write of the table, in order.
    task automatic queueInitWrites();
        initEntry_u e;
        for (int k = 0; k < INIT_LEN; k++)
        begin
            e = INIT_TABLE[k];
            if ((e.wr.kind == KIND_CMD) || (e.wr.kind == KIND_DATA))
                pushExpected(e.wr.kind == KIND_DATA, e.wr.word, curLow, curHigh);
        end
    endtask

    // One-cycle register write strobe.
    task automatic writeReg(input logic [2:0] addr, input logic [15:0] data);
        @(posedge clk);
        regWrite <= 1'b1;
        regAddr  <= addr;
        regWdata <= data;
        @(posedge clk);
        regWrite <= 1'b0;
        regAddr  <= REG_STATUS;
    endtask

    task automatic readReg(input logic [2:0] addr, output logic [15:0] data);
        @(posedge clk);
        regWrite <= 1'b0;
        regAddr  <= addr;
        @(negedge clk);
        data = regRdata; // Stable mid-cycle.
    endtask

    task automatic waitIdle();
        logic [15:0] st;
        st = 16'h0001;
        while (st[0])
            readReg(REG_STATUS, st);
        checkEq(lcdCs, 1'b1, "chip select high between transfers");
        checkEq(st[3], 1'b0, "overrun clear while idle");
    endtask

    // Random widths first, then one launch, sometimes chased by a dropped one.
    task automatic hostLaunch();
        logic [31:0] rnd;
        logic [15:0] word;
        logic [15:0] st;
        logic        isData;
        waitIdle();
        rnd     = $random(seed);
        word    = rnd[31:16];
        isData  = rnd[8];
        curLow  = effWidth(rnd[3:0]);
        curHigh = effWidth(rnd[7:4]);
        writeReg(REG_TIMING, {8'h00, rnd[7:4], rnd[3:0]});
        readReg(REG_TIMING, st);
        checkEq(st, {8'h00, curHigh, curLow}, "timing readback");
        pushExpected(isData, word, curLow, curHigh);
        writeReg(isData ? REG_DATA : REG_CMD, word);
        if (rnd[10:9] == 2'd0)
        begin
            writeReg(rnd[11] ? REG_DATA : REG_CMD, ~word); // Engine still busy.
            readReg(REG_STATUS, st);
            checkEq(st[3], 1'b1, "overrun after launch while busy");
            writeReg(REG_CTRL, 16'h0006); // Clear, backlight stays enabled.
            readReg(REG_STATUS, st);
            checkEq(st[3], 1'b0, "overrun after clear");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Pin monitor.
    ////////////////////////////////////////////////////////////////////////////
    always @(negedge clk)
    begin
        if (rst_n === 1'b1)
        begin
            checkEq(lcdRd, 1'b1, "read strobe held high");
            if (lcdWr === 1'b0)
                checkEq(lcdCs, 1'b0, "write strobe low outside chip select");
            if (lcdRst === 1'b0)
                rstLowCnt++;
            else if (!prevRst)
            begin
                checkEq(rstLowCnt, RESET_LOW_CYCLES, "panel reset low width");
                rstPulses++;
                rstLowCnt = 0;
            end
            // Strobe rise is where the panel latches.
            if (lcdWr === 1'b0)
                wrLowCnt++;
            else if (!prevWr)
            begin
                if (expQ.size() == 0)
                    stopRun("write strobe on the pins with no write expected");
                else
                begin
                    expNow = expQ.pop_front();
                    checkEq(lcdRs, expNow[16], "register select");
                    checkEq(lcdData, expNow[15:0], "data word");
                    checkEq(wrLowCnt, expNow[20:17], "strobe low width");
                    csWidthExp = expNow[20:17] + expNow[24:21];
                end
                wrLowCnt = 0;
            end
            if (lcdCs === 1'b0)
                csLowCnt++;
            else if (!prevCs)
            begin
                checkEq(csLowCnt, csWidthExp, "chip select low width");
                csLowCnt = 0;
            end
            prevRst = lcdRst;
            prevWr  = lcdWr;
            prevCs  = lcdCs;
        end
    end

    // Run limit.
    always @(posedge clk)
    begin
        cycleCnt++;
        if (cycleCnt > cycleLimit)
            stopRun("the run exceeded its cycle limit and timed out");
    end

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence.
    ////////////////////////////////////////////////////////////////////////////
    initial
    begin
        logic [15:0] st;
        cycleLimit = 2 * powerUpCycles() + N_LAUNCH * (MAX_XFER + HOST_OVERHEAD);
        rst_n    = 1'b0;
        regWrite = 1'b0;
        regAddr  = REG_STATUS;
        regWdata = 16'd0;
        curLow   = DEFAULT_WR_LOW;
        curHigh  = DEFAULT_WR_HIGH;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        // Idle pins.
        @(negedge clk);
        checkEq(lcdRst, 1'b1, "panel reset after reset");
        checkEq(lcdCs, 1'b1, "chip select after reset");
        checkEq(lcdRs, 1'b1, "register select after reset");
        checkEq(lcdWr, 1'b1, "write strobe after reset");
        checkEq(lcdData, 16'd0, "data pins after reset");
        checkEq(blCtrl, 1'b0, "backlight after reset");
        readReg(REG_STATUS, st);
        checkEq(st, 16'h0000, "status after reset");

        // Power-up with the backlight enabled.
        queueInitWrites();
        writeReg(REG_CTRL, 16'h0003);
        writeReg(REG_CMD, 16'h00AA); // Sequencer owns the bus so this is dropped.
        readReg(REG_STATUS, st);
        checkEq(st[0], 1'b1, "busy during power-up");
        checkEq(st[3], 1'b1, "overrun after launch during power-up");
        writeReg(REG_CTRL, 16'h0006);
        readReg(REG_STATUS, st);
        checkEq(st[3], 1'b0, "overrun after clear");
        checkEq(blCtrl, 1'b0, "backlight dark before initDone");
        while (!st[1])
            readReg(REG_STATUS, st);
        checkEq(rstPulses, 1, "panel reset pulse count");
        checkEq(expQ.size(), 0, "init writes still expected");
        checkEq(blCtrl, 1'b1, "backlight after initDone");
        checkEq(st[2], 1'b1, "status backlight bit");

        // Backlight follows the enable bit.
        writeReg(REG_CTRL, 16'h0000);
        readReg(REG_STATUS, st);
        checkEq(blCtrl, 1'b0, "backlight with enable cleared");
        checkEq(st[1], 1'b1, "initDone level held");
        readReg(REG_CTRL, st);
        checkEq(st, 16'h0000, "control readback with enable cleared");
        writeReg(REG_CTRL, 16'h0002);
        readReg(REG_STATUS, st);
        checkEq(blCtrl, 1'b1, "backlight with enable set");
        readReg(REG_CTRL, st);
        checkEq(st, 16'h0002, "control readback with enable set");

        for (int i = 0; i < N_LAUNCH; i++)
            hostLaunch();
        waitIdle();

        if ((expQ.size() == 0) && (rstPulses == 1))
        begin
            $display("Testbench passed");
            $finish;
        end
        else
        begin
            $display("Error: %0d expected writes never reached the pins", expQ.size());
            endFailed();
        end
    end

endmodule

// File: vlog.f
lcdPkg.sv
lcdBusTiming.sv
lcdInitSequencer.sv
lcdConfigRegs.sv
lcdController.sv
tbLcd.sv

// File: Bender.yml
package:
  name: lcd_controller

sources:
  - lcdPkg.sv
  - lcdBusTiming.sv
  - lcdInitSequencer.sv
  - lcdConfigRegs.sv
  - lcdController.sv
  - target: simulation
    files:
      - tbLcd.sv
